/* logic/sd_pkg.sv */
// shared types and constants for the SD card sector reader
// host command, controller state, pin and request structs, SPI and sector sizes

package sd_pkg;

  localparam int spi_half_period = 2;   // clk cycles per sclk half period
  localparam int sector_bytes    = 512;
  localparam int sector_index_w  = 9;   // log2(sector_bytes)
  localparam int power_up_bytes  = 10;  // 80 idle clocks with cs_n high

  // host side command, same encoding as the legacy reader
  typedef enum logic [1:0] {
    cmd_idle = 2'd0,
    cmd_read = 2'd1,
    cmd_next = 2'd2
  } sd_cmd_e;

  typedef enum logic [3:0] {
    st_power_up,   // idle bytes, cs_n high
    st_cmd0,       // go idle
    st_cmd1,       // init, repeated until R1 == 0x00
    st_ready,
    st_cmd17,      // single block read
    st_wait_r1,
    st_wait_token,
    st_data,
    st_crc
  } sd_ctrl_state_e;

  typedef struct packed {
    logic cs_n;
    logic sclk;
    logic mosi;
  } sd_spi_pins_t;

  typedef struct packed {
    logic        rd;      // one cycle strobe
    logic [31:0] sector;  // valid with rd
  } sd_block_req_t;

  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } sd_byte_strobe_t;

endpackage

/* logic/spi_byte_engine.sv */
// SPI mode 0 byte shifter with sclk derived from clk
// one byte out on mosi and one byte in from miso per start strobe, MSB first

module spi_byte_engine (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,    // one cycle, tx_byte valid with it
  input  logic [7:0] tx_byte,
  input  logic       miso,
  output logic       sclk,
  output logic       mosi,
  output logic       done,     // one cycle, rx_byte valid with it
  output logic [7:0] rx_byte
);
  import sd_pkg::*;

  typedef logic [$clog2(spi_half_period + 1)-1:0] half_cnt_t;

  half_cnt_t  half_cnt;
  logic       active;
  logic [2:0] bit_cnt;   // counts falling edges
  logic [7:0] sh_out;
  logic [7:0] sh_in;
  logic       half_tick;

  assign half_tick = active && (half_cnt == half_cnt_t'(spi_half_period - 1));
  assign mosi      = sh_out[7];
  assign rx_byte   = sh_in;  // stable since the eighth rising edge

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active   <= 1'b0;
      sclk     <= 1'b0;  // mode 0, idles low
      done     <= 1'b0;
      half_cnt <= '0;
      bit_cnt  <= '0;
      sh_out   <= 8'hFF; // mosi idles high
    end else begin
      done <= 1'b0;
      if (start && !active) begin
        active   <= 1'b1;
        half_cnt <= '0;
        bit_cnt  <= '0;
        sh_out   <= tx_byte;  // first bit on mosi before first rising edge
      end else if (half_tick) begin
        half_cnt <= '0;
        sclk     <= ~sclk;
        if (sclk) begin  // falling edge, present next bit
          sh_out  <= {sh_out[6:0], 1'b1};
          bit_cnt <= bit_cnt + 1'b1;
          if (bit_cnt == 3'd7) begin
            active <= 1'b0;
            done   <= 1'b1;
          end
        end
      end else if (active) begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // sample miso on the rising edge
  always_ff @(posedge clk) begin
    if (half_tick && !sclk) sh_in <= {sh_in[6:0], miso};
  end

endmodule

/* logic/sd_spi_controller.sv */
// SD card SPI mode sequencer: power-up, CMD0, CMD1 loop, CMD17 single block reads
// drives the byte engine one byte at a time and forwards data bytes as strobes

module sd_spi_controller (
  input  logic                    clk,
  input  logic                    rst_n,
  input  sd_pkg::sd_block_req_t   req,
  input  logic [7:0]              rx_byte,
  input  logic                    done,
  output logic                    ready,
  output sd_pkg::sd_byte_strobe_t rx,
  output sd_pkg::sd_ctrl_state_e  status,
  output logic                    start,
  output logic [7:0]              tx_byte,
  output logic                    cs_n
);
  import sd_pkg::*;

  sd_ctrl_state_e            state;
  logic                      waiting;   // byte in flight in the engine
  logic [sector_index_w-1:0] byte_cnt;  // power-up, frame, data and crc bytes
  logic [5:0]                cmd_idx;   // command being exchanged
  logic [31:0]               arg;       // command argument, byte address for CMD17
  logic                      in_frame;
  logic [7:0]                next_tx;
  logic                      rx_valid;
  logic [7:0]                rx_data;

  // six byte command frame: start bits + index, argument, crc + stop bit
  function automatic logic [7:0] frame_byte(input logic [5:0]  idx,
                                            input logic [31:0] a,
                                            input logic [2:0]  k);
    logic [47:0] frame;
    frame = {2'b01, idx, a, (idx == 6'd0) ? 8'h95 : 8'hFF};  // only CMD0 needs a real crc
    return frame[47 - 8 * k -: 8];
  endfunction

  assign in_frame = (state == st_cmd0) || (state == st_cmd1) || (state == st_cmd17);
  assign next_tx  = in_frame ? frame_byte(cmd_idx, arg, byte_cnt[2:0]) : 8'hFF;

  assign ready  = (state == st_ready);
  assign status = state;
  assign rx     = '{valid: rx_valid, data: rx_data};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_power_up;
      cs_n     <= 1'b1;
      start    <= 1'b0;
      waiting  <= 1'b0;
      byte_cnt <= '0;
      cmd_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      start    <= 1'b0;
      rx_valid <= 1'b0;

      if (state == st_ready) begin
        if (req.rd) begin
          state    <= st_cmd17;
          cmd_idx  <= 6'd17;
          arg      <= {req.sector[22:0], 9'h000};  // sector * 512
          byte_cnt <= '0;
        end
      end else if (!waiting) begin
        // drop cs_n one cycle ahead of the first byte of a transaction
        if (cs_n && state != st_power_up) begin
          cs_n <= 1'b0;
        end else begin
          start   <= 1'b1;
          tx_byte <= next_tx;
          waiting <= 1'b1;
        end
      end else if (done) begin
        waiting <= 1'b0;
        case (state)
          st_power_up: begin
            if (byte_cnt == sector_index_w'(power_up_bytes - 1)) begin
              state    <= st_cmd0;
              cmd_idx  <= 6'd0;
              arg      <= '0;
              byte_cnt <= '0;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end

          st_cmd0, st_cmd1, st_cmd17: begin
            if (byte_cnt == sector_index_w'(5)) begin  // last frame byte out
              state    <= st_wait_r1;
              byte_cnt <= '0;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end

          st_wait_r1: begin
            if (rx_byte != 8'hFF) begin  // R1 found
              if (cmd_idx == 6'd17) begin
                state <= st_wait_token;  // keep cs_n low for the block
              end else begin
                cs_n    <= 1'b1;
                cmd_idx <= 6'd1;
                // CMD1 answers 0x00 once the card has left idle
                if (cmd_idx == 6'd1 && rx_byte == 8'h00) state <= st_ready;
                else state <= st_cmd1;
              end
            end
          end

          st_wait_token: begin
            if (rx_byte == 8'hFE) begin
              state    <= st_data;
              byte_cnt <= '0;
            end
          end

          st_data: begin
            rx_valid <= 1'b1;
            rx_data  <= rx_byte;
            if (byte_cnt == sector_index_w'(sector_bytes - 1)) begin
              state    <= st_crc;
              byte_cnt <= '0;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end

          st_crc: begin  // two crc bytes, read and dropped
            if (byte_cnt == sector_index_w'(1)) begin
              state    <= st_ready;
              cs_n     <= 1'b1;
              byte_cnt <= '0;
            end else begin
              byte_cnt <= byte_cnt + 1'b1;
            end
          end

          default: ;
        endcase
      end
    end
  end

endmodule

/* logic/sd_sector_reader.sv */
// host command decoder with the 512 byte sector buffer and its read-out index
// requests block reads from the controller and reports busy

module sd_sector_reader (
  input  logic                    clk,
  input  logic                    rst_n,
  input  sd_pkg::sd_cmd_e         cmd,
  input  logic [31:0]             sector,
  input  logic                    ready,
  input  sd_pkg::sd_byte_strobe_t rx,
  output sd_pkg::sd_block_req_t   req,
  output logic [7:0]              data_out,
  output logic                    busy
);
  import sd_pkg::*;

  typedef enum logic [1:0] {
    rs_init,      // waiting for card init
    rs_idle,
    rs_pre_read,  // controller still shows ready this cycle
    rs_read
  } reader_state_e;

  reader_state_e             state;
  logic [7:0]                buffer [sector_bytes];
  logic [sector_index_w-1:0] index;
  logic                      rd;
  logic [31:0]               sector_q;

  assign data_out = buffer[index];
  assign busy     = (state != rs_idle);
  assign req      = '{rd: rd, sector: sector_q};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= rs_init;
      index <= '0;
      rd    <= 1'b0;
    end else begin
      rd <= 1'b0;
      case (state)
        rs_init: if (ready) state <= rs_idle;

        rs_idle: begin
          if (cmd == cmd_read && ready) begin
            rd       <= 1'b1;
            sector_q <= sector;
            index    <= '0;  // fill from the start of the buffer
            state    <= rs_pre_read;
          end else if (cmd == cmd_next) begin
            index <= index + 1'b1;  // wraps at 512
          end
        end

        rs_pre_read: state <= rs_read;

        rs_read: begin
          if (rx.valid) index <= index + 1'b1;  // back at 0 after the last byte
          if (ready) state <= rs_idle;
        end

        default: state <= rs_init;
      endcase
    end
  end

  // buffer write port
  always_ff @(posedge clk) begin
    if (state == rs_read && rx.valid) buffer[index] <= rx.data;
  end

endmodule

/* logic/sd_reader_top.sv */
// SD card sector reader top: reader, SPI controller and byte engine
// packs chip select, clock and data out into the card pin struct

module sd_reader_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  sd_pkg::sd_cmd_e        cmd,
  input  logic [31:0]            sector,
  input  logic                   miso,
  output logic [7:0]             data_out,
  output logic                   busy,
  output sd_pkg::sd_ctrl_state_e status,
  output sd_pkg::sd_spi_pins_t   spi
);

  sd_pkg::sd_block_req_t   req;
  sd_pkg::sd_byte_strobe_t rx;
  logic                    ready;
  logic                    start;    // controller to engine
  logic                    done;     // engine to controller
  logic [7:0]              tx_byte;
  logic [7:0]              rx_byte;
  logic                    cs_n;
  logic                    sclk;
  logic                    mosi;

  assign spi = '{cs_n: cs_n, sclk: sclk, mosi: mosi};

  sd_sector_reader reader_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .sector   (sector),
    .ready    (ready),
    .rx       (rx),
    .req      (req),
    .data_out (data_out),
    .busy     (busy)
  );

  sd_spi_controller ctrl_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (req),
    .rx_byte (rx_byte),
    .done    (done),
    .ready   (ready),
    .rx      (rx),
    .status  (status),
    .start   (start),
    .tx_byte (tx_byte),
    .cs_n    (cs_n)
  );

  spi_byte_engine engine_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .tx_byte (tx_byte),
    .miso    (miso),
    .sclk    (sclk),
    .mosi    (mosi),
    .done    (done),
    .rx_byte (rx_byte)
  );

endmodule

/* bench/sd_card_model.sv */
// behavioural SPI mode SD card
// answers CMD0, CMD1 and CMD17, block data follows a per-sector byte pattern

module sd_card_model (
  input  sd_pkg::sd_spi_pins_t spi,
  output logic                 miso
);
  import sd_pkg::*;

  logic [7:0] out_sh    = 8'hFF;  // byte going out on miso, MSB first
  logic [7:0] in_sh     = 8'hFF;
  int         bit_cnt   = 0;
  logic [2:0] frame_cnt = '0;
  int         cmd1_cnt  = 0;      // CMD1 reports idle twice before ready
  logic [7:0] frame [6];
  logic [7:0] resp_q [$];         // bytes queued for the host

  assign miso = spi.cs_n ? 1'b1 : out_sh[7];  // pulled up while deselected

  // collect command frames and queue the answer
  task automatic take_byte(input logic [7:0] b);
    logic [31:0] arg;
    logic [31:0] sec;
    if (frame_cnt == 3'd0 && b[7:6] != 2'b01) return;  // filler byte
    frame[frame_cnt] = b;
    frame_cnt = frame_cnt + 3'd1;
    if (frame_cnt != 3'd6) return;
    frame_cnt = '0;
    arg = {frame[1], frame[2], frame[3], frame[4]};
    resp_q.push_back(8'hFF);  // one byte of Ncr before R1
    case (frame[0][5:0])
      6'd0: begin
        resp_q.push_back(8'h01);  // idle
        cmd1_cnt = 0;
      end
      6'd1: begin
        resp_q.push_back((cmd1_cnt < 2) ? 8'h01 : 8'h00);
        cmd1_cnt++;
      end
      6'd17: begin
        sec = arg / 32'd512;  // byte address back to sector
        resp_q.push_back(8'h00);
        resp_q.push_back(8'hFF);
        resp_q.push_back(8'hFF);
        resp_q.push_back(8'hFE);  // start block token
        for (int k = 0; k < sector_bytes; k++) begin
          resp_q.push_back(sec[7:0] + 8'(3 * k));
        end
        resp_q.push_back(8'h3C);  // crc, not checked by the host
        resp_q.push_back(8'hC3);
      end
      default: resp_q.push_back(8'h04);  // illegal command
    endcase
  endtask

  always @(posedge spi.sclk or negedge spi.sclk or posedge spi.cs_n) begin
    if (spi.cs_n) begin  // deselect drops any partial byte
      bit_cnt   = 0;
      frame_cnt = '0;
      out_sh    = 8'hFF;
      resp_q.delete();
    end else if (spi.sclk) begin
      in_sh   = {in_sh[6:0], spi.mosi};  // sample on rising edge
      bit_cnt = bit_cnt + 1;
    end else if (bit_cnt == 8) begin
      // byte finished on this falling edge, next one goes out now
      bit_cnt = 0;
      take_byte(in_sh);
      if (resp_q.size() > 0) out_sh = resp_q.pop_front();
      else out_sh = 8'hFF;
    end else begin
      out_sh = {out_sh[6:0], 1'b1};
    end
  end

endmodule

/* bench/sd_reader_tb.sv */
// testbench for the SD card sector reader
// clock, reset, host stimulus, reference pattern, comparing process, watchdog

module sd_reader_tb;
  import sd_pkg::*;

  localparam int num_reads   = 8;  // sector 5, six random, one with cmd_next while busy
  localparam int byte_cycles = 16 * spi_half_period + 4;  // engine time plus handshake
  localparam int read_cycles = 540 * byte_cycles;        // frame, R1, token, data, crc
  localparam int watchdog_cycles =
    3 * (num_reads * (read_cycles + 2 * sector_bytes) + 60 * byte_cycles);
  localparam int expected_checks = num_reads * (sector_bytes + 1);

  logic           clk = 1'b0;
  logic           rst_n;
  sd_cmd_e        cmd;
  logic [31:0]    sector;
  logic           miso;
  logic [7:0]     data_out;
  logic           busy;
  sd_ctrl_state_e status;
  sd_spi_pins_t   spi;

  logic [31:0]    cur_sector;  // sector the buffer should hold
  int             cur_index;
  int             checks = 0;
  event           check_ev;

  always #2 clk = ~clk;  // period 4

  sd_reader_top dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .sector   (sector),
    .miso     (miso),
    .data_out (data_out),
    .busy     (busy),
    .status   (status),
    .spi      (spi)
  );

  sd_card_model card_i (
    .spi  (spi),
    .miso (miso)
  );

  // low byte of the sector, plus three per byte position
  function automatic logic [7:0] expected_byte(input logic [31:0] s, input int i);
    logic [31:0] step;
    step = 3 * i;
    return s[7:0] + step[7:0];
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Error %s: got %h expected %h", name, got, exp);
    $display("TESTBENCH FAILED");
    $fatal(1, "wrong value on %s", name);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run aborted");
  endtask

  // issue a read, optionally hold cmd_next for the whole busy time, wait for busy to fall
  task automatic read_sector(input logic [31:0] s, input bit next_while_busy);
    cmd    = cmd_read;
    sector = s;
    @(negedge clk);
    cmd = next_while_busy ? cmd_next : cmd_idle;  // must be dropped by the reader
    assert (busy == 1'b1) else report_mismatch("busy", 32'(busy), 32'd1);
    while (busy) @(negedge clk);
    cmd        = cmd_idle;
    cur_sector = s;
    cur_index  = 0;
    -> check_ev;  // first byte, before any cmd_next
  endtask

  task automatic step_index();
    cmd = cmd_next;
    @(negedge clk);
    cmd       = cmd_idle;
    cur_index = (cur_index + 1) % sector_bytes;
    -> check_ev;
  endtask

  // comparing process
  always @(check_ev) begin : compare
    logic [7:0] exp_byte;
    exp_byte = expected_byte(cur_sector, cur_index);
    assert (data_out == exp_byte)
      else report_mismatch("data_out", 32'(data_out), 32'(exp_byte));
    checks++;
  end

  initial begin
    rst_n      = 1'b0;
    cmd        = cmd_idle;
    sector     = '0;
    cur_sector = '0;
    cur_index  = 0;
    void'($urandom(32'hd49bbc32));
    repeat (10) @(posedge clk);
    @(negedge clk);
    assert (busy == 1'b1) else report_mismatch("busy", 32'(busy), 32'd1);
    assert (spi.cs_n == 1'b1) else report_mismatch("spi.cs_n", 32'(spi.cs_n), 32'd1);
    assert (spi.sclk == 1'b0) else report_mismatch("spi.sclk", 32'(spi.sclk), 32'd0);
    assert (status == st_power_up)
      else report_mismatch("status", 32'(status), 32'(st_power_up));
    rst_n = 1'b1;
    @(negedge clk);
    assert (busy == 1'b1) else report_mismatch("busy", 32'(busy), 32'd1);
    assert (status != st_ready) else abort_run("controller ready right after reset");
    while (busy) @(negedge clk);  // card init, length varies
    assert (status == st_ready) else report_mismatch("status", 32'(status), 32'(st_ready));

    read_sector(32'd5, 1'b0);
    repeat (sector_bytes) step_index();  // last step wraps to index 0
    for (int r = 0; r < 6; r++) begin
      read_sector($urandom(), 1'b0);
      repeat (sector_bytes) step_index();
    end
    read_sector(32'h0000_00C3, 1'b1);
    repeat (sector_bytes) step_index();  // a skipped write shows up as a stale byte
    @(negedge clk);

    if (checks == expected_checks) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("compare count %0d, wanted %0d", checks, expected_checks);
      abort_run("comparing process missed some byte checks");
    end
  end

  // watchdog
  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    abort_run("watchdog expired before the tests completed");
  end

endmodule

/* compile.f */
logic/sd_pkg.sv
logic/spi_byte_engine.sv
logic/sd_spi_controller.sv
logic/sd_sector_reader.sv
logic/sd_reader_top.sv
bench/sd_card_model.sv
bench/sd_reader_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SD reader testbench with Verilator and runs it
# the exit status is the simulator's, non-zero on any $fatal
cd "$(dirname "$0")" &&
  verilator --binary --timing --top-module sd_reader_tb -f compile.f -o sd_reader_sim &&
  ./obj_dir/sd_reader_sim ||
  { echo "simulation build or run did not succeed" >&2; exit 1; }
